//--- Makefile
TOP := tb_xcvr_avmm

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f all.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f all.f --top-module xcvr_avmm_top

clean:
	rm -rf obj_dir sim.log

//--- all.f
logic/xcvr_avmm_pkg.sv
logic/xcvr_avmm_ifs.sv
logic/avmm_addr_router.sv
logic/soft_csr.sv
logic/chnl_avmm_bridge.sv
logic/reset_ltr_override.sv
logic/xcvr_avmm_top.sv
tb/tb_xcvr_avmm.sv

//--- logic/avmm_addr_router.sv
`timescale 1ns/1ps
`default_nettype none

module avmm_addr_router
    import xcvr_avmm_pkg::*;
(
    input  wire                          avmm_clk,
    input  wire                          avmm_reset,
    input  wire                          avmm_write,
    input  wire                          avmm_read,
    input  wire avmm_addr_u              avmm_address,
    input  wire logic [avmm_data_w-1:0]  avmm_writedata,
    output logic [avmm_data_w-1:0]       avmm_readdata,
    csr_bus_if.router                    csr,
    chnl_bus_if.router                   chnl
);

    logic csr_sel;     // Current request targets soft CSR
    logic csr_sel_rd;  // Select captured at last read

    assign csr_sel = avmm_address.csr.sel;

    // Soft CSR side, index taken from CSR view
    assign csr.write     = avmm_write & csr_sel;
    assign csr.read      = avmm_read  & csr_sel;
    assign csr.index     = avmm_address.csr.idx;
    assign csr.writedata = avmm_writedata;

    // Hard channel side, address from channel view
    assign chnl.write     = avmm_write & ~csr_sel;
    assign chnl.read      = avmm_read  & ~csr_sel;
    assign chnl.address   = avmm_address.chnl.addr;
    assign chnl.writedata = avmm_writedata;

    // Remember where the read went so the returning word is taken from the right bus
    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            csr_sel_rd <= 1'b0;
        end else if (avmm_read) begin
            csr_sel_rd <= csr_sel;   // Back-to-back reads update every cycle
        end
    end

    // Both readdata registers clear on reset, so output is 0 until first read
    assign avmm_readdata = csr_sel_rd ? csr.readdata : chnl.readdata;

endmodule

`default_nettype wire

//--- logic/chnl_avmm_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module chnl_avmm_bridge
    import xcvr_avmm_pkg::*;
#(
    parameter int n_chnl_blocks = 8
) (
    input  wire                                      avmm_clk,
    input  wire                                      avmm_reset,
    chnl_bus_if.target                               chnl,
    input  wire logic [n_chnl_blocks*avmm_data_w-1:0] blk_readdata,  // Block k at [k*16 +: 16]
    input  wire logic [n_chnl_blocks-1:0]            blk_select,
    output logic                                     chnl_avmm_write,
    output logic                                     chnl_avmm_read,
    output logic [chnl_addr_w-1:0]                   chnl_avmm_address,
    output logic [avmm_data_w-1:0]                   chnl_avmm_writedata,
    output logic [1:0]                               chnl_avmm_byteen
);

    logic [avmm_data_w-1:0] blk_word;   // Word of the selected block
    logic [avmm_data_w-1:0] rdata_q;

    // Request goes straight out, blocks respond in the same cycle
    assign chnl_avmm_write     = chnl.write;
    assign chnl_avmm_read      = chnl.read;
    assign chnl_avmm_address   = chnl.address;
    assign chnl_avmm_writedata = chnl.writedata;
    assign chnl_avmm_byteen    = 2'b11;    // Always full 16-bit access

    // Priority pick, scanning down so the lowest selected index wins
    always_comb begin
        blk_word = '0;                     // Nothing selected reads 0
        for (int k = n_chnl_blocks - 1; k >= 0; k--) begin
            if (blk_select[k]) begin
                blk_word = blk_readdata[k*avmm_data_w +: avmm_data_w];
            end
        end
    end

    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            rdata_q <= '0;
        end else if (chnl.read) begin
            rdata_q <= blk_word;           // Capture only on a channel read
        end
    end

    assign chnl.readdata = rdata_q;

endmodule

`default_nettype wire

//--- logic/reset_ltr_override.sv
`timescale 1ns/1ps
`default_nettype none

module reset_ltr_override #(
    parameter bit use_10g_pcs = 1'b1   // Status source, 10G or 8G PCS
) (
    input  wire  in_pld_8g_txurstpcs_n,
    input  wire  in_pld_8g_rxurstpcs_n,
    input  wire  in_pld_10g_tx_rst_n,
    input  wire  in_pld_10g_rx_rst_n,
    input  wire  rx_crurstn,
    input  wire  in_pld_rxpma_rstb_in,
    input  wire  in_pld_ltr,
    input  wire  rx_ltd,
    input  wire  seriallpbken,
    input  wire  tx_rst_ovr,
    input  wire  tx_digital_rst_n_val,
    input  wire  rx_rst_ovr,
    input  wire  rx_digital_rst_n_val,
    input  wire  rx_analog_rst_n_val,
    input  wire  rx_ltrltd_ovr,
    input  wire  rx_ltr_val,
    input  wire  rx_ltd_val,
    input  wire  csr_seriallpbken,
    output logic out_pld_8g_txurstpcs_n,
    output logic out_pld_8g_rxurstpcs_n,
    output logic out_pld_10g_tx_rst_n,
    output logic out_pld_10g_rx_rst_n,
    output logic out_rx_crurstn,
    output logic out_pld_rxpma_rstb_in,
    output logic csr2pcs_ltr,
    output logic csr2pma_ltd,
    output logic pma_seriallpbken,
    output logic stat_tx_digital_reset,
    output logic stat_rx_digital_reset
);

    // Calibration can take the PCS resets away from the core
    assign out_pld_8g_txurstpcs_n = tx_rst_ovr ? tx_digital_rst_n_val : in_pld_8g_txurstpcs_n;
    assign out_pld_8g_rxurstpcs_n = rx_rst_ovr ? rx_digital_rst_n_val : in_pld_8g_rxurstpcs_n;
    assign out_pld_10g_tx_rst_n   = tx_rst_ovr ? tx_digital_rst_n_val : in_pld_10g_tx_rst_n;
    assign out_pld_10g_rx_rst_n   = rx_rst_ovr ? rx_digital_rst_n_val : in_pld_10g_rx_rst_n;
    // One analog value covers CDR and rxpma_rstb
    assign out_rx_crurstn         = rx_rst_ovr ? rx_analog_rst_n_val  : rx_crurstn;
    assign out_pld_rxpma_rstb_in  = rx_rst_ovr ? rx_analog_rst_n_val  : in_pld_rxpma_rstb_in;

    assign csr2pcs_ltr = rx_ltrltd_ovr ? rx_ltr_val : in_pld_ltr;   // Lock to reference
    assign csr2pma_ltd = rx_ltrltd_ovr ? rx_ltd_val : rx_ltd;       // Lock to data

    assign pma_seriallpbken = seriallpbken | csr_seriallpbken;      // Either side enables

    // Status reads active high, core resets are active low
    assign stat_tx_digital_reset = use_10g_pcs ? ~in_pld_10g_tx_rst_n : ~in_pld_8g_txurstpcs_n;
    assign stat_rx_digital_reset = use_10g_pcs ? ~in_pld_10g_rx_rst_n : ~in_pld_8g_rxurstpcs_n;

endmodule

`default_nettype wire

//--- logic/soft_csr.sv
`timescale 1ns/1ps
`default_nettype none

module soft_csr
    import xcvr_avmm_pkg::*;
(
    input  wire       avmm_clk,
    input  wire       avmm_reset,
    csr_bus_if.target csr,
    input  wire       stat_tx_digital_reset,
    input  wire       stat_rx_digital_reset,
    output logic      tx_rst_ovr,
    output logic      tx_digital_rst_n_val,
    output logic      rx_rst_ovr,
    output logic      rx_digital_rst_n_val,
    output logic      rx_analog_rst_n_val,
    output logic      rx_ltrltd_ovr,
    output logic      rx_ltr_val,
    output logic      rx_ltd_val,
    output logic      csr_seriallpbken
);

    logic [rst_rx_ana_rst_n_b:rst_tx_ovr_b] rst_ovr_q;   // Reset override reg, bits 4:0
    logic [ltd_val_b:ltr_ovr_b]             ltr_ltd_q;   // LTR/LTD override reg, bits 2:0
    logic                                   lpbk_q;      // Serial loopback enable
    logic [avmm_data_w-1:0]                 rd_mux;      // Read word before register
    logic [avmm_data_w-1:0]                 rdata_q;

    // Writable registers; status and unmapped indices drop the write
    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            rst_ovr_q <= '0;
            ltr_ltd_q <= '0;
            lpbk_q    <= 1'b0;
        end else if (csr.write) begin
            case (csr.index)
                csr_idx_rst_ovr:  rst_ovr_q <= csr.writedata[rst_rx_ana_rst_n_b:rst_tx_ovr_b];
                csr_idx_ltr_ltd:  ltr_ltd_q <= csr.writedata[ltd_val_b:ltr_ovr_b];
                csr_idx_loopback: lpbk_q    <= csr.writedata[lpbk_en_b];
                default: ;                                  // Read-only or unmapped
            endcase
        end
    end

    // Read decode, unused bits stay 0
    always_comb begin
        rd_mux = '0;
        case (csr.index)
            csr_idx_rst_ovr: begin
                rd_mux[rst_rx_ana_rst_n_b:rst_tx_ovr_b] = rst_ovr_q;
            end
            csr_idx_ltr_ltd: begin
                rd_mux[ltd_val_b:ltr_ovr_b] = ltr_ltd_q;
            end
            csr_idx_loopback: begin
                rd_mux[lpbk_en_b] = lpbk_q;
            end
            csr_idx_status: begin
                // Live reset status from the selected PCS
                rd_mux[stat_tx_dig_rst_b] = stat_tx_digital_reset;
                rd_mux[stat_rx_dig_rst_b] = stat_rx_digital_reset;
            end
            default: ;                                      // Unmapped reads 0
        endcase
    end

    // Holds last read word between reads
    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            rdata_q <= '0;
        end else if (csr.read) begin
            rdata_q <= rd_mux;
        end
    end

    assign csr.readdata = rdata_q;   // Valid 1 cycle after read

    // Override fields out to the mux block
    assign tx_rst_ovr           = rst_ovr_q[rst_tx_ovr_b];
    assign tx_digital_rst_n_val = rst_ovr_q[rst_tx_dig_rst_n_b];
    assign rx_rst_ovr           = rst_ovr_q[rst_rx_ovr_b];
    assign rx_digital_rst_n_val = rst_ovr_q[rst_rx_dig_rst_n_b];
    assign rx_analog_rst_n_val  = rst_ovr_q[rst_rx_ana_rst_n_b];
    assign rx_ltrltd_ovr        = ltr_ltd_q[ltr_ovr_b];
    assign rx_ltr_val           = ltr_ltd_q[ltr_val_b];
    assign rx_ltd_val           = ltr_ltd_q[ltd_val_b];
    assign csr_seriallpbken     = lpbk_q;

endmodule

`default_nettype wire

//--- logic/xcvr_avmm_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Request side to soft CSR bank; readdata lags read by 1 cycle
interface csr_bus_if
    import xcvr_avmm_pkg::*;
();
    logic                   write;
    logic                   read;
    logic [csr_idx_w-1:0]   index;     // CSR register index
    logic [avmm_data_w-1:0] writedata;
    logic [avmm_data_w-1:0] readdata;  // Registered in the target

    modport router (output write, read, index, writedata, input readdata);
    modport target (input write, read, index, writedata, output readdata);
endinterface

// Request side to hard channel register bus
interface chnl_bus_if
    import xcvr_avmm_pkg::*;
();
    logic                   write;
    logic                   read;
    logic [chnl_addr_w-1:0] address;   // Channel register address
    logic [avmm_data_w-1:0] writedata;
    logic [avmm_data_w-1:0] readdata;  // Registered in the bridge

    modport router (output write, read, address, writedata, input readdata);
    modport target (input write, read, address, writedata, output readdata);
endinterface

`default_nettype wire

//--- logic/xcvr_avmm_pkg.sv
`default_nettype none

package xcvr_avmm_pkg;

    localparam int avmm_data_w = 16;              // Avalon read/write data
    localparam int csr_sel_bit = 11;              // High = soft CSR, low = hard channel regs
    localparam int avmm_addr_w = csr_sel_bit + 1; // Master address, 12 bits
    localparam int chnl_addr_w = csr_sel_bit;     // Channel register address, 11 bits
    localparam int csr_idx_w   = 4;

    // Soft CSR register map
    localparam logic [csr_idx_w-1:0] csr_idx_rst_ovr  = 4'd0;
    localparam logic [csr_idx_w-1:0] csr_idx_ltr_ltd  = 4'd1;
    localparam logic [csr_idx_w-1:0] csr_idx_loopback = 4'd2;
    localparam logic [csr_idx_w-1:0] csr_idx_status   = 4'd3; // Read only

    // Reset override register fields
    localparam int rst_tx_ovr_b        = 0;
    localparam int rst_tx_dig_rst_n_b  = 1;
    localparam int rst_rx_ovr_b        = 2;
    localparam int rst_rx_dig_rst_n_b  = 3;
    localparam int rst_rx_ana_rst_n_b  = 4; // CDR and rxpma_rstb

    localparam int ltr_ovr_b = 0;   // LTR/LTD register
    localparam int ltr_val_b = 1;
    localparam int ltd_val_b = 2;

    localparam int lpbk_en_b = 0;   // Serial loopback enable

    localparam int stat_tx_dig_rst_b = 0;   // Status register
    localparam int stat_rx_dig_rst_b = 1;

    // Same address word, decoded two ways depending on the select bit
    typedef struct packed {
        logic                   sel;
        logic [chnl_addr_w-1:0] addr;
    } chnl_view_t;

    typedef struct packed {
        logic                             sel;
        logic [chnl_addr_w-csr_idx_w-1:0] rsvd;  // Ignored by the CSR decode
        logic [csr_idx_w-1:0]             idx;
    } csr_view_t;

    typedef union packed {
        chnl_view_t chnl;
        csr_view_t  csr;
    } avmm_addr_u;

endpackage

`default_nettype wire

//--- logic/xcvr_avmm_top.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_avmm_top
    import xcvr_avmm_pkg::*;
#(
    parameter int n_chnl_blocks = 8,
    parameter bit use_10g_pcs   = 1'b1
) (
    input  wire                                       avmm_clk,
    input  wire                                       avmm_reset,
    input  wire                                       avmm_write,
    input  wire                                       avmm_read,
    input  wire logic [avmm_addr_w-1:0]               avmm_address,
    input  wire logic [avmm_data_w-1:0]               avmm_writedata,
    output wire logic [avmm_data_w-1:0]               avmm_readdata,
    input  wire logic [n_chnl_blocks*avmm_data_w-1:0] blk_readdata,
    input  wire logic [n_chnl_blocks-1:0]             blk_select,
    output wire                                       chnl_avmm_write,
    output wire                                       chnl_avmm_read,
    output wire logic [chnl_addr_w-1:0]               chnl_avmm_address,
    output wire logic [avmm_data_w-1:0]               chnl_avmm_writedata,
    output wire logic [1:0]                           chnl_avmm_byteen,
    input  wire                                       in_pld_8g_txurstpcs_n,
    input  wire                                       in_pld_8g_rxurstpcs_n,
    input  wire                                       in_pld_10g_tx_rst_n,
    input  wire                                       in_pld_10g_rx_rst_n,
    input  wire                                       rx_crurstn,
    input  wire                                       in_pld_rxpma_rstb_in,
    input  wire                                       in_pld_ltr,
    input  wire                                       rx_ltd,
    input  wire                                       seriallpbken,
    output wire                                       out_pld_8g_txurstpcs_n,
    output wire                                       out_pld_8g_rxurstpcs_n,
    output wire                                       out_pld_10g_tx_rst_n,
    output wire                                       out_pld_10g_rx_rst_n,
    output wire                                       out_rx_crurstn,
    output wire                                       out_pld_rxpma_rstb_in,
    output wire                                       csr2pcs_ltr,
    output wire                                       csr2pma_ltd,
    output wire                                       pma_seriallpbken
);

    // CSR to override mux
    wire tx_rst_ovr, tx_digital_rst_n_val;
    wire rx_rst_ovr, rx_digital_rst_n_val, rx_analog_rst_n_val;
    wire rx_ltrltd_ovr, rx_ltr_val, rx_ltd_val;
    wire csr_seriallpbken;
    wire stat_tx_digital_reset, stat_rx_digital_reset;   // Back into status reg

    csr_bus_if  csr_bus ();
    chnl_bus_if chnl_bus ();

    avmm_addr_router u_router (
        .avmm_clk, .avmm_reset, .avmm_write, .avmm_read,
        .avmm_address, .avmm_writedata, .avmm_readdata,
        .csr  (csr_bus.router),
        .chnl (chnl_bus.router)
    );

    soft_csr u_soft_csr (
        .avmm_clk, .avmm_reset,
        .csr (csr_bus.target),
        .stat_tx_digital_reset, .stat_rx_digital_reset,
        .tx_rst_ovr, .tx_digital_rst_n_val, .rx_rst_ovr, .rx_digital_rst_n_val,
        .rx_analog_rst_n_val, .rx_ltrltd_ovr, .rx_ltr_val, .rx_ltd_val, .csr_seriallpbken
    );

    chnl_avmm_bridge #(.n_chnl_blocks(n_chnl_blocks)) u_chnl_bridge (
        .avmm_clk, .avmm_reset,
        .chnl (chnl_bus.target),
        .blk_readdata, .blk_select,
        .chnl_avmm_write, .chnl_avmm_read, .chnl_avmm_address,
        .chnl_avmm_writedata, .chnl_avmm_byteen
    );

    reset_ltr_override #(.use_10g_pcs(use_10g_pcs)) u_override (
        .in_pld_8g_txurstpcs_n, .in_pld_8g_rxurstpcs_n, .in_pld_10g_tx_rst_n,
        .in_pld_10g_rx_rst_n, .rx_crurstn, .in_pld_rxpma_rstb_in,
        .in_pld_ltr, .rx_ltd, .seriallpbken,
        .tx_rst_ovr, .tx_digital_rst_n_val, .rx_rst_ovr, .rx_digital_rst_n_val,
        .rx_analog_rst_n_val, .rx_ltrltd_ovr, .rx_ltr_val, .rx_ltd_val, .csr_seriallpbken,
        .out_pld_8g_txurstpcs_n, .out_pld_8g_rxurstpcs_n, .out_pld_10g_tx_rst_n,
        .out_pld_10g_rx_rst_n, .out_rx_crurstn, .out_pld_rxpma_rstb_in,
        .csr2pcs_ltr, .csr2pma_ltd, .pma_seriallpbken,
        .stat_tx_digital_reset, .stat_rx_digital_reset
    );

endmodule

`default_nettype wire

//--- tb/tb_xcvr_avmm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xcvr_avmm
    import xcvr_avmm_pkg::*;
();

    localparam int n_blk = 8;

    logic                         avmm_clk       = 1'b0;
    logic                         avmm_reset     = 1'b1;
    logic                         avmm_write     = 1'b0;
    logic                         avmm_read      = 1'b0;
    logic [avmm_addr_w-1:0]       avmm_address   = '0;
    logic [avmm_data_w-1:0]       avmm_writedata = '0;
    logic [8:0]                   core_in        = '0;  // Core resets, LTR/LTD, loopback
    logic [n_blk*avmm_data_w-1:0] blk_readdata;         // From block model below
    logic [n_blk-1:0]             blk_select;
    wire  [avmm_data_w-1:0]       avmm_readdata;
    wire                          chnl_avmm_write;
    wire                          chnl_avmm_read;
    wire  [chnl_addr_w-1:0]       chnl_avmm_address;
    wire  [avmm_data_w-1:0]       chnl_avmm_writedata;
    wire  [1:0]                   chnl_avmm_byteen;
    wire  [8:0]                   ovr_out;              // Same bit order as core_in

    string ovr_names [9] = '{"out_pld_8g_txurstpcs_n", "out_pld_8g_rxurstpcs_n",
        "out_pld_10g_tx_rst_n", "out_pld_10g_rx_rst_n", "out_rx_crurstn",
        "out_pld_rxpma_rstb_in", "csr2pcs_ltr", "csr2pma_ltd", "pma_seriallpbken"};

    logic [avmm_data_w-1:0] blk_word [n_blk] = '{default: '0};  // Per-block random word
    logic [31:0]            lfsr_state = 32'h6e6b4290;
    logic [15:0]            op_q [$];
    logic [15:0]            addr_q [$];
    logic [15:0]            data_q [$];
    logic [15:0]            exp_q [$];
    logic                   rd_pending = 1'b0;   // Read issued last cycle
    logic [15:0]            rd_expect  = '0;
    string                  rd_name;
    int                     errors       = 0;
    int                     total_checks = 0;
    int                     test_checks  = 0;
    int                     test_errors  = 0;
    int                     tests_done   = 0;
    int                     cycle_cnt    = 0;
    int                     cycle_limit  = 0;

    xcvr_avmm_top #(.n_chnl_blocks(n_blk), .use_10g_pcs(1'b1)) uut (
        .avmm_clk, .avmm_reset, .avmm_write, .avmm_read, .avmm_address,
        .avmm_writedata, .avmm_readdata, .blk_readdata, .blk_select,
        .chnl_avmm_write, .chnl_avmm_read, .chnl_avmm_address,
        .chnl_avmm_writedata, .chnl_avmm_byteen,
        .in_pld_8g_txurstpcs_n (core_in[0]), .in_pld_8g_rxurstpcs_n (core_in[1]),
        .in_pld_10g_tx_rst_n   (core_in[2]), .in_pld_10g_rx_rst_n   (core_in[3]),
        .rx_crurstn            (core_in[4]), .in_pld_rxpma_rstb_in  (core_in[5]),
        .in_pld_ltr            (core_in[6]), .rx_ltd                (core_in[7]),
        .seriallpbken          (core_in[8]),
        .out_pld_8g_txurstpcs_n (ovr_out[0]), .out_pld_8g_rxurstpcs_n (ovr_out[1]),
        .out_pld_10g_tx_rst_n   (ovr_out[2]), .out_pld_10g_rx_rst_n   (ovr_out[3]),
        .out_rx_crurstn         (ovr_out[4]), .out_pld_rxpma_rstb_in  (ovr_out[5]),
        .csr2pcs_ltr            (ovr_out[6]), .csr2pma_ltd            (ovr_out[7]),
        .pma_seriallpbken       (ovr_out[8])
    );

    // Hard block bank; block k owns addresses whose low 3 bits equal k
    always_comb begin
        for (int k = 0; k < n_blk; k++) begin
            blk_select[k] = (chnl_avmm_address[2:0] == 3'(k));
            blk_readdata[k*avmm_data_w +: avmm_data_w] = blk_word[k] ^ {5'b0, chnl_avmm_address};
        end
    end

    initial begin
        forever #4 avmm_clk = ~avmm_clk;   // 8 ns period
    end

    always @(posedge avmm_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic refresh_blk_words();
        for (int k = 0; k < n_blk; k++) begin
            for (int b = 0; b < avmm_data_w; b++) begin
                blk_word[k][b] = lfsr_state[31];   // One step per bit taken
                lfsr_state     = lfsr_next(lfsr_state);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        total_checks++;
        test_checks++;
        if (act !== exp) begin
            $display("error: t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // One stimulus line per cycle; driven 1 ns after the edge, comb outputs checked at 2 ns
    task automatic run_step(input logic [15:0] op, input logic [15:0] addr,
                            input logic [15:0] data, input logic [15:0] exp);
        @(posedge avmm_clk);
        #1;
        if (rd_pending) begin
            check_value(rd_name, rd_expect, avmm_readdata);   // Registered, 1 cycle latency
            rd_pending = 1'b0;
        end
        avmm_write     = 1'b0;
        avmm_read      = 1'b0;
        avmm_address   = addr[avmm_addr_w-1:0];
        avmm_writedata = data;
        case (op)
            16'h0: begin
                tests_done++;
                $display("test %0d finished: %0d checks, %0d errors", data, test_checks,
                         test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            16'h1: avmm_write = 1'b1;
            16'h2: begin
                avmm_read  = 1'b1;
                rd_pending = 1'b1;
                rd_expect  = exp;
                rd_name    = "avmm_readdata (soft CSR)";
            end
            16'h3: begin
                refresh_blk_words();               // Fresh words for this read
                avmm_read  = 1'b1;
                rd_pending = 1'b1;
                rd_expect  = blk_word[addr[2:0]] ^ {5'b0, addr[10:0]};
                rd_name    = "avmm_readdata (channel)";
            end
            16'h4: core_in = data[8:0];
            16'h5, 16'h6: ;                        // Override check below, or idle
            default: begin
                $display("Stimulus holds an unknown opcode %h", op);
                errors++;
            end
        endcase
        #1;
        if (op == 16'h1 && !addr[csr_sel_bit]) begin
            check_value("chnl_avmm_write", 16'h1, 16'(chnl_avmm_write));
            check_value("chnl_avmm_address", {5'b0, addr[10:0]}, 16'(chnl_avmm_address));
            check_value("chnl_avmm_writedata", data, chnl_avmm_writedata);
            check_value("chnl_avmm_byteen", 16'h3, 16'(chnl_avmm_byteen));
        end else if (op == 16'h1 || op == 16'h2) begin
            check_value("chnl_avmm_write", 16'h0, 16'(chnl_avmm_write));   // CSR stays local
            check_value("chnl_avmm_read", 16'h0, 16'(chnl_avmm_read));
        end else if (op == 16'h3) begin
            check_value("chnl_avmm_read", 16'h1, 16'(chnl_avmm_read));
        end else if (op == 16'h5) begin
            for (int i = 0; i < 9; i++) begin
                check_value(ovr_names[i], 16'(exp[i]), 16'(ovr_out[i]));
            end
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [15:0] f_op, f_addr, f_data, f_exp;
        fd = $fopen("tb/xcvr_avmm_stimulus.txt", "r");
        if (fd == 0) begin
            $display("The stimulus file tb/xcvr_avmm_stimulus.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines do not parse as four fields
                if ($sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp) == 4) begin
                    op_q.push_back(f_op);
                    addr_q.push_back(f_addr);
                    data_q.push_back(f_data);
                    exp_q.push_back(f_exp);
                end
            end
            $fclose(fd);
            if (op_q.size() == 0) begin
                $display("The stimulus file holds no operations");
                errors++;
            end
        end
        cycle_limit = op_q.size() * 4 + 50;
        repeat (5) @(posedge avmm_clk);
        #1 avmm_reset = 1'b0;
        foreach (op_q[i]) begin
            run_step(op_q[i], addr_q[i], data_q[i], exp_q[i]);
        end
        run_step(16'h6, 16'h0, 16'h0, 16'h0);    // Collect a trailing read
        $display("Totals: %0d tests, %0d checks, %0d errors", tests_done, total_checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/xcvr_avmm_stimulus.txt
// Columns in hex: opcode address data expected
// Opcodes: 0 end of test (data = test number), 1 write, 2 CSR read, 3 channel read, 4 set core inputs, 5 check override outputs
4 000 0155 0000
5 000 0000 0155
2 800 0000 0000
2 801 0000 0000
2 802 0000 0000
2 803 0000 0002
2 80f 0000 0000
0 000 0001 0000
1 800 001f 0000
5 000 0000 017f
1 800 ffe5 0000
5 000 0000 0140
2 800 0000 0005
1 800 001a 0000
5 000 0000 0155
2 800 0000 001a
0 000 0002 0000
4 000 0000 0000
1 801 0007 0000
5 000 0000 00c0
1 801 fff6 0000
5 000 0000 0000
2 801 0000 0006
1 802 0001 0000
5 000 0000 0100
1 802 fffe 0000
4 000 0100 0000
5 000 0000 0100
0 000 0003 0000
4 000 0000 0000
2 803 0000 0003
1 803 ffff 0000
2 803 0000 0003
4 000 0004 0000
2 803 0000 0002
4 000 0008 0000
2 803 0000 0001
0 000 0004 0000
1 123 abcd 0000
1 7ff 0055 0000
3 123 0000 0000
3 2f5 0000 0000
0 000 0005 0000
3 045 0000 0000
2 801 0000 0006
3 7fe 0000 0000
2 803 0000 0001
3 001 0000 0000
2 802 0000 0000
0 000 0006 0000
